// ==== source/mac_pkg.sv ====
/*
 * ethernet framing constants, crc-32 parameters,
 * link status types and the receive byte union
 */
package mac_pkg;

// ----------------------------------------------------------
// stream and frame layout
// ----------------------------------------------------------
localparam int byte_w       = 8;                    // stream data width
localparam int preamble_len = 7;                    // number of 0x55 bytes
localparam int fcs_len      = 4;                    // fcs bytes, lsb first on the wire
localparam int rx_hdr_len   = preamble_len + 1;     // preamble plus sfd
localparam int tx_delay_len = 9;                    // payload delay stages on tx

localparam logic [byte_w-1:0] preamble_byte = 8'h55;
localparam logic [byte_w-1:0] sfd_byte      = 8'hD5;

// ----------------------------------------------------------
// crc-32 (ieee 802.3)
// ----------------------------------------------------------
localparam logic [31:0] crc_init    = 32'hFFFF_FFFF;  // start value
localparam logic [31:0] crc_poly    = 32'hEDB8_8320;  // reflected polynomial
// residue over content plus fcs, in conventional bit order
localparam logic [31:0] crc_residue = 32'hC704_DD7B;

// ----------------------------------------------------------
// in-band link status, sent by the phy during the gap
// ----------------------------------------------------------
typedef enum logic [1:0] {
    speed_10   = 2'b00,     // 2.5 mhz rx clock
    speed_100  = 2'b01,     // 25 mhz
    speed_1000 = 2'b10      // 125 mhz
} link_speed_e;

typedef struct packed {
    logic [3:0]  unused;    // not defined by rgmii
    logic        duplex;    // 1 = full
    link_speed_e speed;
    logic        link_up;
} rx_status_s;

// one received byte, frame data inside a frame or status in the gap
typedef union packed {
    logic [byte_w-1:0] data;
    rx_status_s        status;
} rx_byte_u;

endpackage

// ==== source/mac_crc32.sv ====
/*
 * byte-wide crc-32 engine with clear and enable
 */
`timescale 1ns/1ns

module mac_crc32 import mac_pkg::*; (
    input  logic              mac_rx_clk,
    input  logic              arst_n_i,
    input  logic              crc_clr_i,    // load crc_init
    input  logic              crc_en_i,     // fold crc_data_i in
    input  logic [byte_w-1:0] crc_data_i,
    output logic [31:0]       crc_o         // conventional bit order
);

logic [31:0] crc_q;         // running value, reflected
logic [31:0] crc_next;

// ----------------------------------------------------------
// next value, one bit per step, lsb of the byte first
// ----------------------------------------------------------
always_comb begin
    crc_next = crc_q ^ {{(32 - byte_w){1'b0}}, crc_data_i};
    for (int i = 0; i < byte_w; i++) begin
        if (crc_next[0]) begin
            crc_next = (crc_next >> 1) ^ crc_poly;
        end else begin
            crc_next = crc_next >> 1;
        end
    end
end

// ----------------------------------------------------------
// state register
// ----------------------------------------------------------
always_ff @(posedge mac_rx_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
        crc_q <= crc_init;
    end else if (crc_clr_i) begin       // clear wins over enable
        crc_q <= crc_init;
    end else if (crc_en_i) begin
        crc_q <= crc_next;
    end
end

// bit reversed back to the usual msb-first view
// so the residue and the tx fcs both see the same order
assign crc_o = {<<{crc_q}};

endmodule

// ==== source/mac_rx_framer.sv ====
/*
 * rx framer, preamble stripping, crc check control,
 * in-band status capture and the 4-stage output pipeline
 */
`timescale 1ns/1ns

module mac_rx_framer import mac_pkg::*; (
    input  logic              mac_rx_clk,
    input  logic              arst_n_i,
    input  rx_byte_u          rx_data_i,      // data in frame, status in gap
    input  logic              rx_dv_i,        // rising edge ctl sample
    input  logic              rx_ctl_fall_i,  // falling edge ctl sample
    input  logic [31:0]       crc_i,
    output logic              crc_clr_o,
    output logic              crc_en_o,
    output logic [byte_w-1:0] crc_data_o,
    output logic [byte_w-1:0] mac_rx_data_o,
    output logic              mac_rx_valid_o,
    output logic              mac_rx_sof_o,
    output logic              mac_rx_eof_o,
    output logic              mac_rx_fr_good_o,
    output logic              mac_rx_fr_err_o,
    output rx_status_s        status_o
);

logic [3:0]        hdr_cnt;           // saturates at rx_hdr_len + 1
logic              in_hdr;
logic              in_content;
logic              first_content;
logic              rx_err;
logic              rx_gap;

logic              hdr_q;             // stage 1 byte is preamble or sfd
logic [2:0]        valid_sr;          // stages 1..3
logic [2:0]        sof_sr;
logic [2:0]        err_sr;
logic [2:0]        eof_sr;
logic [1:0]        good_sr;           // stages 2..3
logic [byte_w-1:0] data_sr [3];
logic [1:0]        stat_en_sr;
rx_status_s        stat_sr [2];

// ----------------------------------------------------------
// byte classification
// ----------------------------------------------------------
assign in_hdr        = rx_dv_i && (hdr_cnt <  4'(rx_hdr_len));
assign in_content    = rx_dv_i && (hdr_cnt >= 4'(rx_hdr_len));
assign first_content = rx_dv_i && (hdr_cnt == 4'(rx_hdr_len));
assign rx_err        = rx_dv_i && !rx_ctl_fall_i;     // rx_er during frame
assign rx_gap        = !rx_dv_i && !rx_ctl_fall_i;    // status byte

always_ff @(posedge mac_rx_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
        hdr_cnt <= '0;
    end else if (!rx_dv_i) begin
        hdr_cnt <= '0;                      // restart every frame
    end else if (hdr_cnt <= 4'(rx_hdr_len)) begin
        hdr_cnt <= hdr_cnt + 4'd1;
    end
end

// ----------------------------------------------------------
// flag pipeline, stage 1 feeds the crc engine
// ----------------------------------------------------------
always_ff @(posedge mac_rx_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
        hdr_q      <= 1'b0;
        valid_sr   <= '0;
        sof_sr     <= '0;
        err_sr     <= '0;
        eof_sr     <= '0;
        good_sr    <= '0;
        stat_en_sr <= '0;
    end else begin
        hdr_q      <= in_hdr;
        valid_sr   <= {valid_sr[1:0], in_content};
        sof_sr     <= {sof_sr[1:0], first_content};
        err_sr     <= {err_sr[1:0], rx_err};
        // content ended, one stage behind the last byte
        eof_sr     <= {eof_sr[1:0], valid_sr[0] && !in_content};
        // crc_i settles the cycle after the last enabled byte
        good_sr    <= {good_sr[0], eof_sr[0] && (crc_i == crc_residue)};
        stat_en_sr <= {stat_en_sr[0], rx_gap};
    end
end

// payload side, no reset
always_ff @(posedge mac_rx_clk) begin
    data_sr[0] <= rx_data_i.data;
    data_sr[1] <= data_sr[0];
    data_sr[2] <= data_sr[1];
    stat_sr[0] <= rx_data_i.status;     // same byte, status view
    stat_sr[1] <= stat_sr[0];
end

assign crc_clr_o  = hdr_q;              // cleared while the header passes
assign crc_en_o   = valid_sr[0];
assign crc_data_o = data_sr[0];

// ----------------------------------------------------------
// output stage
// ----------------------------------------------------------
always_ff @(posedge mac_rx_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
        mac_rx_valid_o   <= 1'b0;
        mac_rx_sof_o     <= 1'b0;
        mac_rx_eof_o     <= 1'b0;
        mac_rx_fr_good_o <= 1'b0;
        mac_rx_fr_err_o  <= 1'b0;
        status_o         <= '0;
    end else begin
        mac_rx_valid_o   <= valid_sr[2];
        mac_rx_sof_o     <= sof_sr[2];
        mac_rx_eof_o     <= eof_sr[2];
        mac_rx_fr_good_o <= good_sr[1];
        mac_rx_fr_err_o  <= err_sr[2];
        if (stat_en_sr[1]) begin
            status_o <= stat_sr[1];     // 3 cycles after the gap byte
        end
    end
end

always_ff @(posedge mac_rx_clk) begin
    mac_rx_data_o <= data_sr[2];        // 4 cycles after the input byte
end

endmodule

// ==== source/mac_tx_framer.sv ====
/*
 * tx framer, preamble and sfd insertion, payload delay line
 * and fcs append, lsb byte first
 */
`timescale 1ns/1ns

module mac_tx_framer import mac_pkg::*; (
    input  logic              mac_rx_clk,
    input  logic              arst_n_i,
    input  logic [byte_w-1:0] mac_tx_data_i,
    input  logic              mac_tx_valid_i,
    input  logic              mac_tx_sof_i,
    input  logic              mac_tx_eof_i,
    input  logic [31:0]       crc_i,
    output logic              crc_clr_o,
    output logic              crc_en_o,
    output logic [byte_w-1:0] tx_data_o,
    output logic              tx_dv_o
);

// flag registers load all ones and shift zeros in from the lsb
// so the count of low zeros is the cycles since sof or eof
logic [preamble_len:0]         pre_sr;
logic [tx_delay_len+fcs_len:0] fcs_sr;

logic [byte_w-1:0] dly_q [tx_delay_len];  // payload delay line
logic [31:0]       fcs_word;              // fcs in wire order
logic [31:0]       fcs_calc;

logic              pre_emit;
logic              sfd_emit;
logic              fcs_load;
logic              fcs_emit;
logic              fcs_done;

// ----------------------------------------------------------
// crc engine control
// ----------------------------------------------------------
assign crc_en_o  = mac_tx_valid_i;
assign crc_clr_o = !mac_tx_valid_i;      // idle between frames
assign fcs_calc  = {<<{~crc_i}};         // inverted, back to reflected

// ----------------------------------------------------------
// flag decode
// ----------------------------------------------------------
assign pre_emit = pre_sr[preamble_len-1];                        // 7 x 0x55
assign sfd_emit = pre_sr[preamble_len] && !pre_sr[preamble_len-1];
assign fcs_load = &fcs_sr;                                       // eof just seen
assign fcs_emit = fcs_sr[tx_delay_len+fcs_len-1] && !fcs_sr[tx_delay_len-1];
assign fcs_done = fcs_sr[tx_delay_len+fcs_len] && !fcs_sr[tx_delay_len+fcs_len-1];

always_ff @(posedge mac_rx_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
        pre_sr    <= '0;
        fcs_sr    <= '0;
        tx_dv_o   <= 1'b0;
        tx_data_o <= '0;
    end else begin
        pre_sr <= mac_tx_sof_i ? '1 : (pre_sr << 1);
        fcs_sr <= mac_tx_eof_i ? '1 : (fcs_sr << 1);

        if (&pre_sr) begin
            tx_dv_o <= 1'b1;           // 2 cycles after sof
        end else if (fcs_done) begin
            tx_dv_o <= 1'b0;           // right after the last fcs byte
        end

        // byte mux onto the phy
        if (fcs_emit) begin
            tx_data_o <= fcs_word[byte_w-1:0];
        end else if (sfd_emit) begin
            tx_data_o <= sfd_byte;
        end else if (pre_emit) begin
            tx_data_o <= preamble_byte;
        end else begin
            tx_data_o <= dly_q[tx_delay_len-1];
        end
    end
end

// ----------------------------------------------------------
// payload delay and fcs hold
// ----------------------------------------------------------
always_ff @(posedge mac_rx_clk) begin
    dly_q[0] <= mac_tx_valid_i ? mac_tx_data_i : '0;   // zeros between frames
    for (int i = 1; i < tx_delay_len; i++) begin
        dly_q[i] <= dly_q[i-1];
    end

    if (fcs_load) begin
        fcs_word <= fcs_calc;           // crc_i is final one cycle after eof
    end else if (fcs_emit) begin
        fcs_word <= fcs_word >> byte_w; // next byte to the bottom
    end
end

endmodule

// ==== source/mac_core.sv ====
/*
 * mac framing core, rx and tx framers with one crc-32 engine each
 */
`timescale 1ns/1ns

module mac_core import mac_pkg::*; (
    input  logic              mac_rx_clk,
    input  logic              arst_n_i,
    // rx, phy side
    input  logic [byte_w-1:0] rx_data_i,
    input  logic              rx_dv_i,
    input  logic              rx_ctl_fall_i,
    // rx, user side
    output logic [byte_w-1:0] mac_rx_data_o,
    output logic              mac_rx_valid_o,
    output logic              mac_rx_sof_o,
    output logic              mac_rx_eof_o,
    output logic              mac_rx_fr_good_o,
    output logic              mac_rx_fr_err_o,
    output rx_status_s        status_o,
    // tx, user side
    input  logic [byte_w-1:0] mac_tx_data_i,
    input  logic              mac_tx_valid_i,
    input  logic              mac_tx_sof_i,
    input  logic              mac_tx_eof_i,
    // tx, phy side
    output logic [byte_w-1:0] tx_data_o,
    output logic              tx_dv_o
);

logic              rx_crc_clr;
logic              rx_crc_en;
logic [byte_w-1:0] rx_crc_data;
logic [31:0]       rx_crc_val;
logic              tx_crc_clr;
logic              tx_crc_en;
logic [31:0]       tx_crc_val;

// ----------------------------------------------------------
// rx channel
// ----------------------------------------------------------
mac_rx_framer rx_framer (
    .mac_rx_clk       (mac_rx_clk),
    .arst_n_i         (arst_n_i),
    .rx_data_i        (rx_data_i),
    .rx_dv_i          (rx_dv_i),
    .rx_ctl_fall_i    (rx_ctl_fall_i),
    .crc_i            (rx_crc_val),
    .crc_clr_o        (rx_crc_clr),
    .crc_en_o         (rx_crc_en),
    .crc_data_o       (rx_crc_data),
    .mac_rx_data_o    (mac_rx_data_o),
    .mac_rx_valid_o   (mac_rx_valid_o),
    .mac_rx_sof_o     (mac_rx_sof_o),
    .mac_rx_eof_o     (mac_rx_eof_o),
    .mac_rx_fr_good_o (mac_rx_fr_good_o),
    .mac_rx_fr_err_o  (mac_rx_fr_err_o),
    .status_o         (status_o)
);

mac_crc32 rx_crc (
    .mac_rx_clk (mac_rx_clk),
    .arst_n_i   (arst_n_i),
    .crc_clr_i  (rx_crc_clr),
    .crc_en_i   (rx_crc_en),
    .crc_data_i (rx_crc_data),     // stage 1 byte
    .crc_o      (rx_crc_val)
);

// ----------------------------------------------------------
// tx channel
// ----------------------------------------------------------
mac_tx_framer tx_framer (
    .mac_rx_clk     (mac_rx_clk),
    .arst_n_i       (arst_n_i),
    .mac_tx_data_i  (mac_tx_data_i),
    .mac_tx_valid_i (mac_tx_valid_i),
    .mac_tx_sof_i   (mac_tx_sof_i),
    .mac_tx_eof_i   (mac_tx_eof_i),
    .crc_i          (tx_crc_val),
    .crc_clr_o      (tx_crc_clr),
    .crc_en_o       (tx_crc_en),
    .tx_data_o      (tx_data_o),
    .tx_dv_o        (tx_dv_o)
);

mac_crc32 tx_crc (
    .mac_rx_clk (mac_rx_clk),
    .arst_n_i   (arst_n_i),
    .crc_clr_i  (tx_crc_clr),
    .crc_en_i   (tx_crc_en),
    .crc_data_i (mac_tx_data_i),   // undelayed payload
    .crc_o      (tx_crc_val)
);

endmodule

// ==== tests/mac_core_asserts.sv ====
/*
 * concurrent checks on the rx stream protocol, bound to the rx framer
 */
`timescale 1ns/1ns

module mac_core_asserts (
    input logic mac_rx_clk,
    input logic arst_n_i,
    input logic valid_i,
    input logic sof_i,
    input logic eof_i,
    input logic good_i
);

// ----------------------------------------------------------
// stream rules
// ----------------------------------------------------------
sof_has_valid: assert property (@(posedge mac_rx_clk) disable iff (!arst_n_i)
    sof_i |-> valid_i)
    else $error("sof without valid on the rx stream");

good_has_eof: assert property (@(posedge mac_rx_clk) disable iff (!arst_n_i)
    good_i |-> eof_i)
    else $error("good frame flag outside eof");

eof_after_data: assert property (@(posedge mac_rx_clk) disable iff (!arst_n_i)
    eof_i |-> !valid_i)          // eof sits one cycle past the last byte
    else $error("valid still high in the eof cycle");

endmodule

bind mac_rx_framer mac_core_asserts rx_asserts (
    .mac_rx_clk (mac_rx_clk),
    .arst_n_i   (arst_n_i),
    .valid_i    (mac_rx_valid_o),
    .sof_i      (mac_rx_sof_o),
    .eof_i      (mac_rx_eof_o),
    .good_i     (mac_rx_fr_good_o)
);

// ==== tests/tb_mac_core.sv ====
/*
 * testbench for mac_core, golden frames from a hex file,
 * output monitor, per-test checks and a cycle limit
 */
`timescale 1ns/1ns

module tb_mac_core import mac_pkg::*; ();

localparam int max_frames = 8;
localparam int gap_len    = 24;     // idle plus pipeline drain per test

logic       mac_rx_clk;
logic       arst_n;
logic [7:0] rx_data_r;
logic       rx_dv_r;
logic       rx_fall_r;
logic       loop_en;                // tx phy side fed back into rx
logic [7:0] rx_data_w;
logic       rx_dv_w;
logic       rx_fall_w;
logic [7:0] tx_data;
logic       tx_valid;
logic       tx_sof;
logic       tx_eof;
logic [7:0] mac_rx_data_o;
logic       mac_rx_valid_o;
logic       mac_rx_sof_o;
logic       mac_rx_eof_o;
logic       mac_rx_fr_good_o;
logic       mac_rx_fr_err_o;
rx_status_s status_o;
logic [7:0] tx_data_o;
logic       tx_dv_o;

// golden data, unpacked per frame
logic [7:0]  gold [0:511];
logic [7:0]  pay  [max_frames][256];
int          flen [max_frames];
logic [31:0] fcs  [max_frames];
logic [7:0]  stat [max_frames];
int          nf;
integer      seed;

// monitor state
int         cyc;
int         cyc_limit;
int         tx_sof_cyc;
int         tx_rise_cyc;
int         tx_done_cnt;
logic       tx_dv_d;
int         in_idx;
int         rx_sof_cyc;
int         rx_eof_cyc;
int         rx_eof_cnt;
logic       rx_good;
logic [7:0] tx_q [$];
logic [7:0] rx_q [$];
int         rxc_q [$];              // output cycle of each rx byte
int         inc_q [$];              // input cycle of each content byte
int         erri_q [$];
int         erro_q [$];

int err_cnt;
int err_mark;
int pass_cnt;
int fail_cnt;

assign rx_data_w = loop_en ? tx_data_o : rx_data_r;
assign rx_dv_w   = loop_en ? tx_dv_o   : rx_dv_r;
assign rx_fall_w = loop_en ? tx_dv_o   : rx_fall_r;    // no rx_er in loopback

mac_core dut0 (
    .mac_rx_clk       (mac_rx_clk),
    .arst_n_i         (arst_n),
    .rx_data_i        (rx_data_w),
    .rx_dv_i          (rx_dv_w),
    .rx_ctl_fall_i    (rx_fall_w),
    .mac_rx_data_o    (mac_rx_data_o),
    .mac_rx_valid_o   (mac_rx_valid_o),
    .mac_rx_sof_o     (mac_rx_sof_o),
    .mac_rx_eof_o     (mac_rx_eof_o),
    .mac_rx_fr_good_o (mac_rx_fr_good_o),
    .mac_rx_fr_err_o  (mac_rx_fr_err_o),
    .status_o         (status_o),
    .mac_tx_data_i    (tx_data),
    .mac_tx_valid_i   (tx_valid),
    .mac_tx_sof_i     (tx_sof),
    .mac_tx_eof_i     (tx_eof),
    .tx_data_o        (tx_data_o),
    .tx_dv_o          (tx_dv_o)
);

always #50 mac_rx_clk = ~mac_rx_clk;

// ----------------------------------------------------------
// reference model
// ----------------------------------------------------------
function automatic logic [31:0] frame_crc(input int i);
    logic [31:0] c;
    c = 32'hFFFF_FFFF;
    for (int k = 0; k < flen[i]; k++) begin
        c = c ^ {24'h0, pay[i][k]};
        for (int b = 0; b < 8; b++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
        end
    end
    return ~c;
endfunction

// byte k of the frame as seen on the wire, preamble first
function automatic logic [7:0] wire_byte(input int i, input int k);
    logic [31:0] f;
    f = fcs[i] >> (8 * (k - 8 - flen[i]));
    if (k < 7) return 8'h55;
    if (k == 7) return 8'hD5;
    if (k < 8 + flen[i]) return pay[i][k-8];
    return f[7:0];
endfunction

// ----------------------------------------------------------
// monitor, samples at the falling edge
// ----------------------------------------------------------
always @(negedge mac_rx_clk) begin
    cyc = cyc + 1;
    if (tx_sof) tx_sof_cyc = cyc;
    if (tx_dv_o) begin
        if (!tx_dv_d) tx_rise_cyc = cyc;
        tx_q.push_back(tx_data_o);
    end else if (tx_dv_d) begin
        tx_done_cnt++;
    end
    tx_dv_d = tx_dv_o;
    if (rx_dv_w) begin
        if (in_idx >= 8) inc_q.push_back(cyc);     // past preamble and sfd
        if (!rx_fall_w) erri_q.push_back(cyc);
        in_idx++;
    end else begin
        in_idx = 0;
    end
    if (mac_rx_valid_o) begin
        rx_q.push_back(mac_rx_data_o);
        rxc_q.push_back(cyc);
    end
    if (mac_rx_sof_o) rx_sof_cyc = cyc;
    if (mac_rx_eof_o) begin
        rx_eof_cyc = cyc;
        rx_good    = mac_rx_fr_good_o;
        rx_eof_cnt++;
    end
    if (mac_rx_fr_err_o) erro_q.push_back(cyc);
end

always @(negedge mac_rx_clk) begin
    if (cyc_limit > 0 && cyc > cyc_limit) begin
        $display("run stopped, cycle limit %0d reached", cyc_limit);
        $display("Simulation FAILED");
        $finish;
    end
end

// ----------------------------------------------------------
// tasks
// ----------------------------------------------------------
task automatic end_test(input string name);
    if (err_cnt == err_mark) begin
        pass_cnt++;
        $display("%s: pass", name);
    end else begin
        fail_cnt++;
        $display("%s: FAIL", name);
    end
    err_mark = err_cnt;
endtask

task automatic clear_queues();
    tx_q.delete();
    rx_q.delete();
    rxc_q.delete();
    inc_q.delete();
    erri_q.delete();
    erro_q.delete();
endtask

task automatic drive_tx(input int i);
    for (int k = 0; k < flen[i]; k++) begin
        @(posedge mac_rx_clk);
        tx_data  <= pay[i][k];
        tx_valid <= 1'b1;
        tx_sof   <= (k == 0);
        tx_eof   <= (k == flen[i] - 1);
    end
    @(posedge mac_rx_clk);
    tx_data  <= 8'h00;
    tx_valid <= 1'b0;
    tx_sof   <= 1'b0;
    tx_eof   <= 1'b0;
endtask

// flip_at and err_at count payload bytes, a negative value means none
task automatic drive_rx(input int i, input int flip_at, input int err_at);
    logic [7:0] b;
    for (int k = 0; k < flen[i] + 12; k++) begin
        b = wire_byte(i, k);
        if (flip_at >= 0 && k == 8 + flip_at) b = b ^ 8'h01;   // corrupt one payload bit
        @(posedge mac_rx_clk);
        rx_data_r <= b;
        rx_dv_r   <= 1'b1;
        rx_fall_r <= !(err_at >= 0 && k == 8 + err_at);
    end
    @(posedge mac_rx_clk);
    rx_data_r <= 8'h00;
    rx_dv_r   <= 1'b0;
    rx_fall_r <= 1'b1;                           // idle, no status
endtask

task automatic wait_rx_eof(input int start_cnt, input int bound);
    int guard;
    guard = 0;
    while (rx_eof_cnt == start_cnt && guard < bound) begin
        @(negedge mac_rx_clk);
        guard++;
    end
    if (rx_eof_cnt == start_cnt) begin
        $display("no rx eof within %0d cycles", bound);
        err_cnt++;
    end
endtask

task automatic check_tx(input int i);
    int guard;
    int start_cnt;
    start_cnt = tx_done_cnt;
    guard = 0;
    clear_queues();
    drive_tx(i);
    while (tx_done_cnt == start_cnt && guard < flen[i] + 40) begin
        @(negedge mac_rx_clk);
        guard++;
    end
    if (tx_done_cnt == start_cnt) begin
        $display("tx frame %0d never ended, tx_dv_o stuck", i);
        err_cnt++;
    end else begin
        if (tx_rise_cyc - tx_sof_cyc != 2) begin
            $display("ERR tx_dv_o rise offset got %h expected %h", tx_rise_cyc - tx_sof_cyc, 2);
            err_cnt++;
        end
        if (tx_q.size() != flen[i] + 12) begin
            $display("ERR tx_dv_o length got %h expected %h", tx_q.size(), flen[i] + 12);
            err_cnt++;
        end else begin
            for (int k = 0; k < flen[i] + 12; k++) begin
                if (tx_q[k] != wire_byte(i, k)) begin
                    $display("ERR tx_data_o byte %0d got %h expected %h",
                             k, tx_q[k], wire_byte(i, k));
                    err_cnt++;
                end
            end
        end
    end
    repeat (16) @(posedge mac_rx_clk);
endtask

task automatic check_rx(input int i, input int flip_at, input int err_at, input logic exp_good);
    logic [7:0] e;
    int last;
    if (rx_q.size() != flen[i] + 4 || inc_q.size() != flen[i] + 4) begin
        $display("ERR mac_rx_valid_o count got %h expected %h", rx_q.size(), flen[i] + 4);
        err_cnt++;
    end else begin
        for (int j = 0; j < flen[i] + 4; j++) begin
            e = wire_byte(i, j + 8);
            if (j == flip_at) e = e ^ 8'h01;
            if (rx_q[j] != e) begin
                $display("ERR mac_rx_data_o byte %0d got %h expected %h", j, rx_q[j], e);
                err_cnt++;
            end
            if (rxc_q[j] != inc_q[j] + 4) begin
                $display("rx byte %0d arrived %0d cycles after input, not 4",
                         j, rxc_q[j] - inc_q[j]);
                err_cnt++;
            end
        end
        last = rxc_q[flen[i] + 3];
        if (rx_sof_cyc != rxc_q[0]) begin
            $display("mac_rx_sof_o not on the first content byte");
            err_cnt++;
        end
        if (rx_eof_cyc != last + 1) begin
            $display("mac_rx_eof_o not in the cycle after the last byte");
            err_cnt++;
        end
    end
    if (rx_good != exp_good) begin
        $display("ERR mac_rx_fr_good_o got %h expected %h", rx_good, exp_good);
        err_cnt++;
    end
    if (err_at < 0 && erro_q.size() != 0) begin
        $display("unexpected mac_rx_fr_err_o pulse");
        err_cnt++;
    end
    if (err_at >= 0) begin
        if (erro_q.size() != 1 || erri_q.size() != 1) begin
            $display("ERR mac_rx_fr_err_o pulses got %h expected %h", erro_q.size(), 1);
            err_cnt++;
        end else if (erro_q[0] != erri_q[0] + 4) begin
            $display("mac_rx_fr_err_o came %0d cycles after the error byte, not 4",
                     erro_q[0] - erri_q[0]);
            err_cnt++;
        end
    end
endtask

task automatic run_rx(input int i, input int flip_at, input int err_at, input logic exp_good);
    int start_cnt;
    start_cnt = rx_eof_cnt;
    clear_queues();
    drive_rx(i, flip_at, err_at);
    wait_rx_eof(start_cnt, 40);
    check_rx(i, flip_at, err_at, exp_good);
    repeat (16) @(posedge mac_rx_clk);
endtask

task automatic check_status(input int i);
    rx_status_s prev;
    prev = status_o;
    @(posedge mac_rx_clk);
    rx_data_r <= stat[i];
    rx_dv_r   <= 1'b0;
    rx_fall_r <= 1'b0;                           // gap byte carries status
    @(negedge mac_rx_clk);
    repeat (2) @(negedge mac_rx_clk);
    if (status_o != prev) begin
        $display("ERR status_o early got %h expected %h", status_o, prev);
        err_cnt++;
    end
    @(negedge mac_rx_clk);
    if (status_o != stat[i]) begin
        $display("ERR status_o got %h expected %h", status_o, stat[i]);
        err_cnt++;
    end
    @(posedge mac_rx_clk);
    rx_fall_r <= 1'b1;
    repeat (4) @(posedge mac_rx_clk);
endtask

task automatic run_loop(input int i);
    int start_cnt;
    start_cnt = rx_eof_cnt;
    clear_queues();
    drive_tx(i);
    wait_rx_eof(start_cnt, flen[i] + 60);
    check_rx(i, -1, -1, 1'b1);
    repeat (16) @(posedge mac_rx_clk);
endtask

// ----------------------------------------------------------
// main sequence
// ----------------------------------------------------------
initial begin
    int p;
    int total;
    mac_rx_clk  = 1'b0;
    arst_n      = 1'b0;
    rx_data_r   = 8'h00;
    rx_dv_r     = 1'b0;
    rx_fall_r   = 1'b1;
    loop_en     = 1'b0;
    tx_data     = 8'h00;
    tx_valid    = 1'b0;
    tx_sof      = 1'b0;
    tx_eof      = 1'b0;
    cyc         = 0;
    cyc_limit   = 0;
    tx_done_cnt = 0;
    rx_eof_cnt  = 0;
    in_idx      = 0;
    tx_dv_d     = 1'b0;
    rx_good     = 1'b0;
    err_cnt     = 0;
    err_mark    = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    seed        = 32'haf1c2208;

    $readmemh("tests/mac_golden.hex", gold);
    p = 0;
    nf = 0;
    while ((gold[p] == 8'h01 || gold[p] == 8'h02) && nf < max_frames) begin
        flen[nf] = int'(gold[p+1]);
        if (gold[p] == 8'h01) begin
            for (int k = 0; k < flen[nf]; k++) pay[nf][k] = gold[p+2+k];
            p = p + 2 + flen[nf];
            fcs[nf] = {gold[p+3], gold[p+2], gold[p+1], gold[p]};
            stat[nf] = gold[p+4];
            p = p + 5;
        end else begin
            for (int k = 0; k < flen[nf]; k++) pay[nf][k] = 8'($random(seed));
            fcs[nf] = frame_crc(nf);
            stat[nf] = gold[p+2];
            p = p + 3;
        end
        nf++;
    end

    // four framed tests per frame, one error frame, reset and status on top
    total = 10 + flen[0] + 12 + gap_len;
    for (int i = 0; i < nf; i++) total = total + 4 * (flen[i] + 12 + gap_len) + 8;
    cyc_limit = 2 * total + 200;

    repeat (10) @(posedge mac_rx_clk);
    arst_n <= 1'b1;
    @(negedge mac_rx_clk);
    if (nf == 0) begin
        $display("golden file holds no frames");
        err_cnt++;
    end
    if (mac_rx_valid_o || mac_rx_sof_o || mac_rx_eof_o || mac_rx_fr_good_o
            || mac_rx_fr_err_o || tx_dv_o || status_o != 8'h00) begin
        $display("outputs not idle after reset");
        err_cnt++;
    end
    end_test("reset state");

    for (int i = 0; i < nf; i++) begin
        check_tx(i);
        end_test($sformatf("tx framing, frame %0d", i));
        check_status(i);
        end_test($sformatf("status capture, frame %0d", i));
        run_rx(i, -1, -1, 1'b1);
        if (status_o != stat[i]) begin
            $display("ERR status_o after frame got %h expected %h", status_o, stat[i]);
            err_cnt++;
        end
        end_test($sformatf("rx good frame %0d", i));
        run_rx(i, 0, -1, 1'b0);
        end_test($sformatf("rx corrupted frame %0d", i));
    end

    if (nf > 0) begin
        run_rx(0, -1, (flen[0] > 2) ? 2 : 0, 1'b1);
        end_test("rx error byte");
    end

    @(posedge mac_rx_clk);
    loop_en <= 1'b1;
    repeat (4) @(posedge mac_rx_clk);
    for (int i = 0; i < nf; i++) begin
        run_loop(i);
        end_test($sformatf("loopback frame %0d", i));
    end

    $display("tests %0d, passed %0d, failed %0d, check errors %0d",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
        $display("Simulation PASSED");
    end else begin
        $display("Simulation FAILED");
    end
    $finish;
end

endmodule

// ==== tests/mac_golden.hex ====
// per record: kind len payload[0..len-1] fcs[7:0] fcs[15:8] fcs[23:16] fcs[31:24] status
// kind 01 fixed payload, kind 02 random payload (kind len status only), 00 ends the list
// status byte is unused[7:4] duplex[3] speed[2:1] link_up[0]

// ascii 123456789, crc 0xCBF43926
01 09
31 32 33 34 35 36 37 38 39
26 39 F4 CB
0D

// ascii abc, crc 0x352441C2
01 03
61 62 63
C2 41 24 35
03

// single byte a, crc 0xE8B7BE43
01 01
61
43 BE B7 E8
01

// minimum size ethernet payload, random fill
02 2E
0C

// 64 byte random payload, gigabit full duplex up
02 40
0D

// end of list
00

// ==== filelist.f ====
source/mac_pkg.sv
source/mac_crc32.sv
source/mac_rx_framer.sv
source/mac_tx_framer.sv
source/mac_core.sv
tests/mac_core_asserts.sv
tests/tb_mac_core.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mac_core \
		-f filelist.f -Mdir obj_dir
	./obj_dir/Vtb_mac_core > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi
	@grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
